/* rab_axil_pkg.sv */
// AXI4-Lite widths, response codes and request structs shared by the RAB config blocks
`default_nettype none

package rab_axil_pkg;

  localparam int unsigned AXIL_ADDR_W = 32;
  localparam int unsigned AXIL_DATA_W = 64;
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // one accepted write, valid is high for a single cycle
  typedef struct packed {
    logic                   valid;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_wr_req_t;

  // valid stays high from the AR handshake until the read data is taken
  typedef struct packed {
    logic                   valid;
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_rd_req_t;

endpackage

`default_nettype wire

/* rab_cfg_pkg.sv */
// RAB address map, slice layout and miss-handling types, imported by the register blocks
`default_nettype none

package rab_cfg_pkg;

  // config words first, then four 64-bit words per slice
  localparam int unsigned N_SLICES    = 4;
  localparam int unsigned N_CFG_WORDS = 4;
  localparam int unsigned N_REGS      = N_CFG_WORDS + 4 * N_SLICES;
  localparam int unsigned WORD_LSB    = 3;
  localparam int unsigned REG_IDX_W   = $clog2(N_REGS);

  // byte addresses
  localparam int unsigned CONFIG_SIZE = N_CFG_WORDS << WORD_LSB;
  localparam int unsigned SLICE_END   = N_REGS << WORD_LSB;
  localparam int unsigned MH_ADDR_OFS = 'h00;
  localparam int unsigned MH_META_OFS = 'h08;
  localparam int unsigned CTRL_OFS    = 'h0C;

  // field widths kept by the slice words
  localparam int unsigned ADDR_W_VIRT = 32;
  localparam int unsigned ADDR_W_PHYS = 40;
  localparam int unsigned N_FLAGS     = 4;
  localparam int unsigned MISS_META_W = 10;

  localparam int unsigned MH_FIFO_DEPTH  = 16;
  localparam int unsigned META_EMPTY_BIT = 31;

  // bit 0 is fifos_disabled
  typedef struct packed {
    logic write_cfg_disabled;
    logic allow_multi_hit;
    logic fifos_disabled;
  } ctrl_reg_t;

  // one translation miss from the lookup side
  typedef struct packed {
    logic                   valid;
    logic [ADDR_W_VIRT-1:0] addr;
    logic [MISS_META_W-1:0] meta;
  } mh_miss_t;

  // masked slice words as seen by the L1 lookup
  typedef logic [N_REGS-N_CFG_WORDS-1:0][63:0] l1_cfg_t;

endpackage

`default_nettype wire

/* rab_mh_fifo.sv */
// synchronous FIFO for miss addresses and miss metadata, head entry shown on dout_o
`default_nettype none

module rab_mh_fifo #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 16
) (
  input  logic              Clk_CI,
  input  logic              Rst_RBI,
  input  logic              push_i,
  input  logic [DATA_W-1:0] din_i,
  input  logic              pop_i,
  output logic [DATA_W-1:0] dout_o,
  output logic              empty_o,
  output logic              full_o
);

  logic [DATA_W-1:0]            mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   cnt_q;
  logic                         do_push, do_pop;

  assign empty_o = (cnt_q == 0);
  assign full_o  = (cnt_q == DEPTH);

  // push into a full FIFO and pop from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= din_i;
  end

  assign dout_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* rab_axil_slave.sv */
// AXI4-Lite slave front end, turns bus traffic into one write pulse and one held read request
`default_nettype none

module rab_axil_slave (
  input  logic                                  Clk_CI,
  input  logic                                  Rst_RBI,
  input  logic [rab_axil_pkg::AXIL_ADDR_W-1:0]  s_axi_awaddr_i,
  input  logic                                  s_axi_awvalid_i,
  output logic                                  s_axi_awready_o,
  input  logic [rab_axil_pkg::AXIL_DATA_W-1:0]  s_axi_wdata_i,
  input  logic [rab_axil_pkg::AXIL_STRB_W-1:0]  s_axi_wstrb_i,
  input  logic                                  s_axi_wvalid_i,
  output logic                                  s_axi_wready_o,
  output logic [1:0]                            s_axi_bresp_o,
  output logic                                  s_axi_bvalid_o,
  input  logic                                  s_axi_bready_i,
  input  logic [rab_axil_pkg::AXIL_ADDR_W-1:0]  s_axi_araddr_i,
  input  logic                                  s_axi_arvalid_i,
  output logic                                  s_axi_arready_o,
  output logic [rab_axil_pkg::AXIL_DATA_W-1:0]  s_axi_rdata_o,
  output logic [1:0]                            s_axi_rresp_o,
  output logic                                  s_axi_rvalid_o,
  input  logic                                  s_axi_rready_i,
  output rab_axil_pkg::axil_wr_req_t            wr_req_o,
  output rab_axil_pkg::axil_rd_req_t            rd_req_o,
  output logic                                  rd_fire_o,
  input  logic                                  wr_ok_i,
  input  logic [rab_axil_pkg::AXIL_DATA_W-1:0]  rd_data_i
);
  import rab_axil_pkg::*;

  logic                   aw_done_q, w_done_q, bvalid_q, rvalid_q;
  logic [1:0]             bresp_q;
  logic                   aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic                   wr_pulse;
  logic [AXIL_ADDR_W-1:0] awaddr_q, araddr_q;
  logic [AXIL_DATA_W-1:0] wdata_q, rdata_q;
  logic [AXIL_STRB_W-1:0] wstrb_q;

  // each ready is low while its channel holds an accepted beat
  assign aw_hs = s_axi_awvalid_i && !aw_done_q;
  assign w_hs  = s_axi_wvalid_i && !w_done_q;
  assign b_hs  = bvalid_q && s_axi_bready_i;
  assign ar_hs = s_axi_arvalid_i && !rvalid_q;
  assign r_hs  = rvalid_q && s_axi_rready_i;

  // fires once both halves are in and no response is pending
  assign wr_pulse = aw_done_q && w_done_q && !bvalid_q;

  // AW channel
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      aw_done_q <= 1'b0;
    else if (aw_hs)
      aw_done_q <= 1'b1;
    else if (b_hs)
      aw_done_q <= 1'b0;
  end

  // W channel
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      w_done_q <= 1'b0;
    else if (w_hs)
      w_done_q <= 1'b1;
    else if (b_hs)
      w_done_q <= 1'b0;
  end

  // B channel, the response code is sampled with the write pulse
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      bvalid_q <= 1'b0;
      bresp_q  <= RESP_OKAY;
    end
    else if (wr_pulse)
    begin
      bvalid_q <= 1'b1;
      bresp_q  <= wr_ok_i ? RESP_OKAY : RESP_SLVERR;
    end
    else if (b_hs)
      bvalid_q <= 1'b0;
  end

  // AR and R channels share one flag, arready comes back after the R handshake
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      rvalid_q <= 1'b0;
    else if (ar_hs)
      rvalid_q <= 1'b1;
    else if (r_hs)
      rvalid_q <= 1'b0;
  end

  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      awaddr_q <= s_axi_awaddr_i;
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    // read data is frozen at the AR handshake so it holds under back-pressure
    if (ar_hs)
    begin
      araddr_q <= s_axi_araddr_i;
      rdata_q  <= rd_data_i;
    end
  end

  assign wr_req_o = '{valid: wr_pulse, addr: awaddr_q, data: wdata_q, strb: wstrb_q};

  // during the AR handshake the request carries the bus address directly
  assign rd_req_o.valid = ar_hs || rvalid_q;
  assign rd_req_o.addr  = rvalid_q ? araddr_q : s_axi_araddr_i;
  assign rd_fire_o      = r_hs;

  assign s_axi_awready_o = !aw_done_q;
  assign s_axi_wready_o  = !w_done_q;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_bresp_o   = bresp_q;
  assign s_axi_arready_o = !rvalid_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = RESP_OKAY;

endmodule

`default_nettype wire

/* rab_l1_slice_regs.sv */
// L1 slice register file, byte-strobed writes masked per word kind and slice read-back
`default_nettype none

module rab_l1_slice_regs (
  input  logic                                  Clk_CI,
  input  logic                                  Rst_RBI,
  input  rab_axil_pkg::axil_wr_req_t            wr_req_i,
  input  logic                                  wr_ok_i,
  input  rab_axil_pkg::axil_rd_req_t            rd_req_i,
  output logic [rab_axil_pkg::AXIL_DATA_W-1:0]  slice_rd_data_o,
  output rab_cfg_pkg::l1_cfg_t                  l1_cfg_o
);
  import rab_axil_pkg::*;
  import rab_cfg_pkg::*;

  l1_cfg_t                l1_q;
  logic                   wr_hit, rd_hit;
  logic [REG_IDX_W-1:0]   wr_idx, rd_idx;
  logic [AXIL_DATA_W-1:0] wr_word;

  function automatic logic in_slice_region(input logic [AXIL_ADDR_W-1:0] addr);
    return (addr >= CONFIG_SIZE) && (addr < SLICE_END);
  endfunction

  // low index bits select virtual, physical or flags word
  function automatic logic [AXIL_DATA_W-1:0] kind_mask(input logic [1:0] kind);
    logic [AXIL_DATA_W-1:0] mask;
    mask = '0;
    if (!kind[1])
      mask[ADDR_W_VIRT-1:0] = '1;
    else if (!kind[0])
      mask[ADDR_W_PHYS-1:0] = '1;
    else
      mask[N_FLAGS-1:0] = '1;
    return mask;
  endfunction

  // slice words are numbered from zero after the config words
  assign wr_idx = wr_req_i.addr[WORD_LSB +: REG_IDX_W] - REG_IDX_W'(N_CFG_WORDS);
  assign rd_idx = rd_req_i.addr[WORD_LSB +: REG_IDX_W] - REG_IDX_W'(N_CFG_WORDS);

  assign wr_hit = wr_req_i.valid && wr_ok_i && in_slice_region(wr_req_i.addr);
  assign rd_hit = rd_req_i.valid && in_slice_region(rd_req_i.addr);

  // merge strobed bytes into the old word, then drop unused bits
  always_comb
  begin
    wr_word = l1_q[wr_idx];
    for (int b = 0; b < AXIL_STRB_W; b++)
    begin
      if (wr_req_i.strb[b])
        wr_word[8*b +: 8] = wr_req_i.data[8*b +: 8];
    end
    wr_word = wr_word & kind_mask(wr_idx[1:0]);
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      l1_q <= '0;
    else if (wr_hit)
      l1_q[wr_idx] <= wr_word;
  end

  assign l1_cfg_o        = l1_q;
  assign slice_rd_data_o = rd_hit ? l1_q[rd_idx] : '0;

endmodule

`default_nettype wire

/* rab_mh_cfg_regs.sv */
// control register, miss FIFO push and pop control, read-data mux and write permission
`default_nettype none

module rab_mh_cfg_regs (
  input  logic                                  Clk_CI,
  input  logic                                  Rst_RBI,
  input  rab_axil_pkg::axil_wr_req_t            wr_req_i,
  input  rab_axil_pkg::axil_rd_req_t            rd_req_i,
  input  logic                                  rd_fire_i,
  input  rab_cfg_pkg::mh_miss_t                 miss_i,
  input  logic [rab_axil_pkg::AXIL_DATA_W-1:0]  slice_rd_data_i,
  output logic                                  addr_push_o,
  output logic [rab_cfg_pkg::ADDR_W_VIRT-1:0]   addr_din_o,
  output logic                                  addr_pop_o,
  input  logic [rab_cfg_pkg::ADDR_W_VIRT-1:0]   addr_dout_i,
  input  logic                                  addr_empty_i,
  input  logic                                  addr_full_i,
  output logic                                  meta_push_o,
  output logic [rab_cfg_pkg::MISS_META_W-1:0]   meta_din_o,
  output logic                                  meta_pop_o,
  input  logic [rab_cfg_pkg::MISS_META_W-1:0]   meta_dout_i,
  input  logic                                  meta_empty_i,
  input  logic                                  meta_full_i,
  output logic                                  wr_ok_o,
  output logic [rab_axil_pkg::AXIL_DATA_W-1:0]  rd_data_o,
  output logic                                  mh_fifo_full_o,
  output logic                                  l1_allow_multi_hit_o
);
  import rab_axil_pkg::*;
  import rab_cfg_pkg::*;

  ctrl_reg_t ctrl_q;
  logic      cfg_wr, ctrl_wr, sw_addr_wr, sw_meta_wr;
  logic      rd_addr_fifo, rd_meta_fifo;
  logic      rd_busy_q, addr_arm_q, meta_arm_q;

  // the config region stays writable so software can always clear the lock
  assign wr_ok_o = (wr_req_i.addr < CONFIG_SIZE) || !ctrl_q.write_cfg_disabled;

  assign cfg_wr     = wr_req_i.valid && (wr_req_i.addr < CONFIG_SIZE);
  assign ctrl_wr    = cfg_wr && (wr_req_i.addr == CTRL_OFS);
  assign sw_addr_wr = cfg_wr && (wr_req_i.addr == MH_ADDR_OFS);
  assign sw_meta_wr = cfg_wr && (wr_req_i.addr == MH_META_OFS);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      ctrl_q <= '0;
    else if (ctrl_wr)
      ctrl_q <= ctrl_reg_t'(wr_req_i.data[$bits(ctrl_reg_t)-1:0]);
  end

  assign l1_allow_multi_hit_o = ctrl_q.allow_multi_hit;

  // a miss fills both FIFOs and beats a software push in the same cycle
  assign addr_push_o = !ctrl_q.fifos_disabled && (miss_i.valid || sw_addr_wr);
  assign meta_push_o = !ctrl_q.fifos_disabled && (miss_i.valid || sw_meta_wr);
  assign addr_din_o  = miss_i.valid ? miss_i.addr : wr_req_i.data[ADDR_W_VIRT-1:0];
  assign meta_din_o  = miss_i.valid ? miss_i.meta : wr_req_i.data[MISS_META_W-1:0];

  assign mh_fifo_full_o = (addr_push_o && addr_full_i) || (meta_push_o && meta_full_i);

  assign rd_addr_fifo = (rd_req_i.addr == MH_ADDR_OFS);
  assign rd_meta_fifo = (rd_req_i.addr == MH_META_OFS);

  // FIFO state is sampled along with the read data, the pop waits for the R handshake
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_busy_q  <= 1'b0;
      addr_arm_q <= 1'b0;
      meta_arm_q <= 1'b0;
    end
    else if (rd_fire_i)
    begin
      rd_busy_q  <= 1'b0;
      addr_arm_q <= 1'b0;
      meta_arm_q <= 1'b0;
    end
    else if (rd_req_i.valid && !rd_busy_q)
    begin
      rd_busy_q  <= 1'b1;
      addr_arm_q <= rd_addr_fifo && !addr_empty_i;
      meta_arm_q <= rd_meta_fifo && !meta_empty_i;
    end
  end

  assign addr_pop_o = rd_fire_i && addr_arm_q;
  assign meta_pop_o = rd_fire_i && meta_arm_q;

  // config words are decoded here, anything above comes from the slice file
  always_comb
  begin
    rd_data_o = '0;
    if (rd_req_i.addr >= CONFIG_SIZE)
      rd_data_o = slice_rd_data_i;
    else if (rd_addr_fifo)
      rd_data_o[ADDR_W_VIRT-1:0] = addr_dout_i;
    else if (rd_meta_fifo)
    begin
      rd_data_o[META_EMPTY_BIT]    = meta_empty_i;
      rd_data_o[MISS_META_W-1:0]   = meta_dout_i;
    end
    else if (rd_req_i.addr == CTRL_OFS)
      rd_data_o[$bits(ctrl_reg_t)-1:0] = ctrl_q;
  end

endmodule

`default_nettype wire

/* rab_cfg_top.sv */
// top of the RAB config port, wires the AXI4-Lite slave to the slice file and miss FIFOs
`default_nettype none

module rab_cfg_top (
  input  logic                                  Clk_CI,
  input  logic                                  Rst_RBI,
  input  logic [rab_axil_pkg::AXIL_ADDR_W-1:0]  s_axi_awaddr_i,
  input  logic                                  s_axi_awvalid_i,
  output logic                                  s_axi_awready_o,
  input  logic [rab_axil_pkg::AXIL_DATA_W-1:0]  s_axi_wdata_i,
  input  logic [rab_axil_pkg::AXIL_STRB_W-1:0]  s_axi_wstrb_i,
  input  logic                                  s_axi_wvalid_i,
  output logic                                  s_axi_wready_o,
  output logic [1:0]                            s_axi_bresp_o,
  output logic                                  s_axi_bvalid_o,
  input  logic                                  s_axi_bready_i,
  input  logic [rab_axil_pkg::AXIL_ADDR_W-1:0]  s_axi_araddr_i,
  input  logic                                  s_axi_arvalid_i,
  output logic                                  s_axi_arready_o,
  output logic [rab_axil_pkg::AXIL_DATA_W-1:0]  s_axi_rdata_o,
  output logic [1:0]                            s_axi_rresp_o,
  output logic                                  s_axi_rvalid_o,
  input  logic                                  s_axi_rready_i,
  input  rab_cfg_pkg::mh_miss_t                 miss_i,
  output logic                                  mh_fifo_full_o,
  output rab_cfg_pkg::l1_cfg_t                  l1_cfg_o,
  output logic                                  l1_allow_multi_hit_o
);
  import rab_axil_pkg::*;
  import rab_cfg_pkg::*;

  axil_wr_req_t           wr_req;
  axil_rd_req_t           rd_req;
  logic                   wr_ok, rd_fire;
  logic [AXIL_DATA_W-1:0] rd_data, slice_rd_data;
  logic                   addr_push, addr_pop, addr_empty, addr_full;
  logic [ADDR_W_VIRT-1:0] addr_din, addr_dout;
  logic                   meta_push, meta_pop, meta_empty, meta_full;
  logic [MISS_META_W-1:0] meta_din, meta_dout;

  rab_axil_slave u_axil_slave (
    .Clk_CI, .Rst_RBI,
    .s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
    .s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
    .wr_req_o  (wr_req),
    .rd_req_o  (rd_req),
    .rd_fire_o (rd_fire),
    .wr_ok_i   (wr_ok),
    .rd_data_i (rd_data)
  );

  rab_l1_slice_regs u_slice_regs (
    .Clk_CI, .Rst_RBI,
    .wr_req_i        (wr_req),
    .wr_ok_i         (wr_ok),
    .rd_req_i        (rd_req),
    .slice_rd_data_o (slice_rd_data),
    .l1_cfg_o
  );

  rab_mh_cfg_regs u_mh_cfg_regs (
    .Clk_CI, .Rst_RBI,
    .wr_req_i        (wr_req),
    .rd_req_i        (rd_req),
    .rd_fire_i       (rd_fire),
    .miss_i,
    .slice_rd_data_i (slice_rd_data),
    .addr_push_o     (addr_push),
    .addr_din_o      (addr_din),
    .addr_pop_o      (addr_pop),
    .addr_dout_i     (addr_dout),
    .addr_empty_i    (addr_empty),
    .addr_full_i     (addr_full),
    .meta_push_o     (meta_push),
    .meta_din_o      (meta_din),
    .meta_pop_o      (meta_pop),
    .meta_dout_i     (meta_dout),
    .meta_empty_i    (meta_empty),
    .meta_full_i     (meta_full),
    .wr_ok_o         (wr_ok),
    .rd_data_o       (rd_data),
    .mh_fifo_full_o,
    .l1_allow_multi_hit_o
  );

  rab_mh_fifo #(.DATA_W(ADDR_W_VIRT), .DEPTH(MH_FIFO_DEPTH)) u_addr_fifo (
    .Clk_CI, .Rst_RBI,
    .push_i  (addr_push),
    .din_i   (addr_din),
    .pop_i   (addr_pop),
    .dout_o  (addr_dout),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  rab_mh_fifo #(.DATA_W(MISS_META_W), .DEPTH(MH_FIFO_DEPTH)) u_meta_fifo (
    .Clk_CI, .Rst_RBI,
    .push_i  (meta_push),
    .din_i   (meta_din),
    .pop_i   (meta_pop),
    .dout_o  (meta_dout),
    .empty_o (meta_empty),
    .full_o  (meta_full)
  );

endmodule

`default_nettype wire

/* rab_cfg_props.sv */
// AXI4-Lite response channel rules, bound into the slave for simulation
`default_nettype none

module rab_cfg_props (
  input logic                                  Clk_CI,
  input logic                                  Rst_RBI,
  input logic                                  bvalid_i,
  input logic                                  bready_i,
  input logic [1:0]                            bresp_i,
  input logic                                  rvalid_i,
  input logic                                  rready_i,
  input logic [rab_axil_pkg::AXIL_DATA_W-1:0]  rdata_i,
  input logic                                  awready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  b_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("bvalid dropped or bresp changed before bready");

  r_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid dropped or rdata changed before rready");

  // no new write address while a response is pending
  aw_block: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i |-> !awready_i)
    else $error("awready high while bvalid is pending");

endmodule

bind rab_axil_slave rab_cfg_props u_props (
  .Clk_CI,
  .Rst_RBI,
  .bvalid_i  (s_axi_bvalid_o),
  .bready_i  (s_axi_bready_i),
  .bresp_i   (s_axi_bresp_o),
  .rvalid_i  (s_axi_rvalid_o),
  .rready_i  (s_axi_rready_i),
  .rdata_i   (s_axi_rdata_o),
  .awready_i (s_axi_awready_o)
);

`default_nettype wire

/* tb_rab_cfg.sv */
// testbench for the RAB config port that runs AXI4-Lite traffic and misses against a reference model
`default_nettype none

module tb_rab_cfg;
  timeunit 1ns;
  timeprecision 100ps;
  import rab_axil_pkg::*;
  import rab_cfg_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_SLICE_WR = 48;
  // slice writes and reads plus the FIFO and control tests
  localparam int N_TRANS    = 2 * N_SLICE_WR + 100;

  logic                   Clk_CI, Rst_RBI;
  logic [AXIL_ADDR_W-1:0] s_axi_awaddr_i, s_axi_araddr_i;
  logic                   s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
  logic [AXIL_DATA_W-1:0] s_axi_wdata_i, s_axi_rdata_o;
  logic [AXIL_STRB_W-1:0] s_axi_wstrb_i;
  logic [1:0]             s_axi_bresp_o, s_axi_rresp_o;
  logic                   s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
  logic                   s_axi_rvalid_o, s_axi_rready_i, mh_fifo_full_o, l1_allow_multi_hit_o;
  mh_miss_t               miss_i;
  l1_cfg_t                l1_cfg_o;

  // reference state
  logic [63:0]            slice_model [16];
  logic [31:0]            addr_q [$];
  logic [9:0]             meta_q [$];
  logic [2:0]             ctrl_model;
  logic [15:0]            lfsr_state = 16'd18462;

  // results waiting for the compare process
  string                  name_q [$];
  logic [63:0]            got_q [$], exp_q [$], mask_q [$];
  int                     n_checks, n_errs;

  rab_cfg_top dut (.*);

  always #(CLK_PERIOD / 2) Clk_CI = ~Clk_CI;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // strobed merge into the old word and then keep the bits of the word kind
  function automatic logic [63:0] slice_expect(input logic [63:0] old_word,
                                               input logic [63:0] data,
                                               input logic [7:0] strb, input int idx);
    logic [63:0] word;
    int          width;
    word = old_word;
    for (int b = 0; b < 8; b++)
      if (strb[b])
        word[8*b +: 8] = data[8*b +: 8];
    case (idx % 4)
      2:       width = 40;
      3:       width = 4;
      default: width = 32;
    endcase
    return word & ((64'd1 << width) - 64'd1);
  endfunction

  function automatic void queue_check(input string name, input logic [63:0] got,
                                      input logic [63:0] exp, input logic [63:0] mask);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    mask_q.push_back(mask);
  endfunction

  always @(negedge Clk_CI)
  begin : compare
    string       name;
    logic [63:0] got, exp, mask;
    while (name_q.size() > 0)
    begin
      name = name_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      mask = mask_q.pop_front();
      n_checks++;
      if ((got & mask) !== (exp & mask))
      begin
        n_errs++;
        $display("[ERROR] %s got 0x%h expected 0x%h", name, got & mask, exp & mask);
      end
    end
  end

  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, output logic [1:0] resp);
    logic aw_pend, w_pend;
    @(posedge Clk_CI);
    s_axi_awaddr_i  <= addr;
    s_axi_awvalid_i <= 1'b1;
    s_axi_wdata_i   <= data;
    s_axi_wstrb_i   <= strb;
    s_axi_wvalid_i  <= 1'b1;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    // AW and W may be taken in different cycles
    while (aw_pend || w_pend)
    begin
      @(posedge Clk_CI);
      if (aw_pend && s_axi_awready_o)
      begin
        s_axi_awvalid_i <= 1'b0;
        aw_pend = 1'b0;
      end
      if (w_pend && s_axi_wready_o)
      begin
        s_axi_wvalid_i <= 1'b0;
        w_pend = 1'b0;
      end
    end
    s_axi_bready_i <= 1'b1;
    do
      @(posedge Clk_CI);
    while (!s_axi_bvalid_o);
    resp = s_axi_bresp_o;
    s_axi_bready_i <= 1'b0;
  endtask

  // hold keeps rready low for that many cycles after rvalid
  task automatic axi_read(input logic [31:0] addr, input int hold,
                          input logic [63:0] exp, input logic [63:0] mask);
    @(posedge Clk_CI);
    s_axi_araddr_i  <= addr;
    s_axi_arvalid_i <= 1'b1;
    do
      @(posedge Clk_CI);
    while (!s_axi_arready_o);
    s_axi_arvalid_i <= 1'b0;
    do
      @(posedge Clk_CI);
    while (!s_axi_rvalid_o);
    // rdata is compared in every cycle that rvalid waits for rready
    queue_check("s_axi_rdata_o", s_axi_rdata_o, exp, mask);
    repeat (hold)
    begin
      @(posedge Clk_CI);
      queue_check("s_axi_rdata_o", s_axi_rdata_o, exp, mask);
    end
    s_axi_rready_i <= 1'b1;
    @(posedge Clk_CI);
    queue_check("s_axi_rdata_o", s_axi_rdata_o, exp, mask);
    queue_check("s_axi_rresp_o", s_axi_rresp_o, RESP_OKAY, '1);
    s_axi_rready_i <= 1'b0;
  endtask

  task automatic write_cfg(input logic [31:0] addr, input logic [63:0] data);
    logic [1:0] resp;
    axi_write(addr, data, 8'hFF, resp);
    queue_check("s_axi_bresp_o", resp, RESP_OKAY, '1);
    if (addr == MH_ADDR_OFS && !ctrl_model[0] && addr_q.size() < MH_FIFO_DEPTH)
      addr_q.push_back(data[31:0]);
    else if (addr == MH_META_OFS && !ctrl_model[0] && meta_q.size() < MH_FIFO_DEPTH)
      meta_q.push_back(data[9:0]);
    else if (addr == CTRL_OFS)
      ctrl_model = data[2:0];
  endtask

  task automatic write_slice(input int idx, input logic [63:0] data, input logic [7:0] strb);
    logic [1:0] resp;
    axi_write(CONFIG_SIZE + 8 * idx, data, strb, resp);
    queue_check("s_axi_bresp_o", resp, ctrl_model[2] ? RESP_SLVERR : RESP_OKAY, '1);
    if (!ctrl_model[2])
      slice_model[idx] = slice_expect(slice_model[idx], data, strb, idx);
    queue_check("l1_cfg_o", l1_cfg_o[idx], slice_model[idx], '1);
  endtask

  task automatic read_slice(input int idx);
    axi_read(CONFIG_SIZE + 8 * idx, 0, slice_model[idx], '1);
  endtask

  task automatic read_ctrl();
    axi_read(CTRL_OFS, 0, {61'd0, ctrl_model}, '1);
    queue_check("l1_allow_multi_hit_o", l1_allow_multi_hit_o, ctrl_model[1], 64'd1);
  endtask

  // full flag is sampled while the miss is presented
  task automatic send_miss(input logic [63:0] addr_bits, input logic [63:0] meta_bits);
    logic exp_full;
    exp_full = !ctrl_model[0] && (addr_q.size() >= MH_FIFO_DEPTH);
    @(posedge Clk_CI);
    miss_i <= '{valid: 1'b1, addr: addr_bits[31:0], meta: meta_bits[9:0]};
    @(negedge Clk_CI);
    queue_check("mh_fifo_full_o", mh_fifo_full_o, exp_full, 64'd1);
    @(posedge Clk_CI);
    miss_i.valid <= 1'b0;
    if (!ctrl_model[0] && !exp_full)
    begin
      addr_q.push_back(addr_bits[31:0]);
      meta_q.push_back(meta_bits[9:0]);
    end
  endtask

  task automatic read_addr_entry(input int hold);
    axi_read(MH_ADDR_OFS, hold, {32'd0, addr_q.pop_front()}, '1);
  endtask

  // an empty FIFO only shows the flag at bit 31
  task automatic read_meta_entry(input int hold);
    if (meta_q.size() == 0)
      axi_read(MH_META_OFS, hold, 64'h8000_0000, 64'h8000_0000);
    else
      axi_read(MH_META_OFS, hold, {54'd0, meta_q.pop_front()}, '1);
  endtask

  initial
  begin
    Clk_CI          = 1'b0;
    Rst_RBI         = 1'b0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b0;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;
    miss_i          = '0;
    ctrl_model      = '0;
    foreach (slice_model[i])
      slice_model[i] = '0;
    repeat (8) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    // strobed slice writes that visit every word three times
    for (int n = 0; n < N_SLICE_WR; n++)
    begin
      write_slice(n % 16, rand_bits(64), rand_bits(8));
      read_slice(n % 16);
    end
    foreach (slice_model[i])
      queue_check("l1_cfg_o", l1_cfg_o[i], slice_model[i], '1);

    // misses come back in arrival order
    read_meta_entry(0);
    repeat (4) send_miss(rand_bits(32), rand_bits(10));
    repeat (4)
    begin
      read_addr_entry(0);
      read_meta_entry(0);
    end
    read_meta_entry(0);

    // software pushes and then misses up to full and one more that overflows
    repeat (4)
    begin
      write_cfg(MH_ADDR_OFS, rand_bits(64));
      write_cfg(MH_META_OFS, rand_bits(64));
    end
    repeat (13) send_miss(rand_bits(32), rand_bits(10));
    repeat (16)
    begin
      read_addr_entry(0);
      read_meta_entry(0);
    end
    read_meta_entry(0);

    // back-pressure on the read channel
    repeat (2) send_miss(rand_bits(32), rand_bits(10));
    read_addr_entry(5);
    read_meta_entry(5);
    read_addr_entry(3);
    read_meta_entry(0);
    read_meta_entry(4);

    // fifos disabled and multi-hit allowed
    write_cfg(CTRL_OFS, 64'h3);
    read_ctrl();
    repeat (2) send_miss(rand_bits(32), rand_bits(10));
    read_meta_entry(0);
    write_cfg(CTRL_OFS, 64'h0);
    read_ctrl();

    // locked slice file
    write_cfg(CTRL_OFS, 64'h4);
    read_ctrl();
    write_slice(5, rand_bits(64), 8'hFF);
    read_slice(5);
    write_cfg(CTRL_OFS, 64'h0);
    read_ctrl();

    repeat (2) @(negedge Clk_CI);
    $display("%0d checks, %0d errors", n_checks, n_errs);
    if (n_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin : watchdog
    #(N_TRANS * 200 * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", N_TRANS * 200);
    $display("%0d checks, %0d errors", n_checks, n_errs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rab_axil_pkg.sv
rab_cfg_pkg.sv
rab_mh_fifo.sv
rab_axil_slave.sv
rab_l1_slice_regs.sv
rab_mh_cfg_regs.sv
rab_cfg_top.sv
rab_cfg_props.sv
tb_rab_cfg.sv
